// File: design/cpu_arch_pkg.sv
/*
  machine-wide sizes: word width, steps per instruction, ram depth
  and bit positions of the caez flag word
*/
package cpu_arch_pkg;

  localparam int WORD_W    = 8;              // data and address width
  localparam int STEP_N    = 6;              // steps per instruction, one-hot stepper width
  localparam int RAM_DEPTH = 1 << WORD_W;    // full 8-bit address space

  // flag word is {c, a, e, z}
  localparam int FLAG_W = 4;
  localparam int FLAG_C = 3;                 // carry out
  localparam int FLAG_A = 2;                 // a larger than b
  localparam int FLAG_E = 1;                 // a equal to b
  localparam int FLAG_Z = 0;                 // result zero

endpackage

// File: design/cpu_isa_pkg.sv
/*
  instruction set: opcodes, alu operation codes, jump condition and io bits,
  and the instruction byte decoded in alu and general form
*/
package cpu_isa_pkg;

  // general opcodes, top instruction bit clear
  localparam logic [3:0] OPC_LD    = 4'd0;   // rb <= ram[ra]
  localparam logic [3:0] OPC_ST    = 4'd1;   // ram[ra] <= rb
  localparam logic [3:0] OPC_DATA  = 4'd2;   // rb <= next byte
  localparam logic [3:0] OPC_JMPR  = 4'd3;   // iar <= rb
  localparam logic [3:0] OPC_JMP   = 4'd4;   // iar <= next byte
  localparam logic [3:0] OPC_JCAEZ = 4'd5;   // conditional jump on caez mask
  localparam logic [3:0] OPC_CLF   = 4'd6;   // clear flags
  localparam logic [3:0] OPC_IO    = 4'd7;   // in / out, data or address

  // alu operations, top instruction bit set
  localparam logic [2:0] ALU_ADD = 3'd0;
  localparam logic [2:0] ALU_SHR = 3'd1;
  localparam logic [2:0] ALU_SHL = 3'd2;
  localparam logic [2:0] ALU_NOT = 3'd3;
  localparam logic [2:0] ALU_AND = 3'd4;
  localparam logic [2:0] ALU_OR  = 3'd5;
  localparam logic [2:0] ALU_XOR = 3'd6;
  localparam logic [2:0] ALU_CMP = 3'd7;

  // jcaez mask bits in the low nibble, same order as the flag word
  localparam int JC_C = 3;
  localparam int JC_A = 2;
  localparam int JC_E = 1;
  localparam int JC_Z = 0;

  // io low nibble: {out, addr, rb}
  localparam int IO_OUT_BIT  = 3;            // 1 = output, 0 = input
  localparam int IO_ADDR_BIT = 2;            // 1 = address, 0 = data

  typedef union packed {
    struct packed {
      logic       is_alu;                    // selects alu form
      logic [2:0] alu_op;
      logic [1:0] ra;
      logic [1:0] rb;
    } alu;
    struct packed {
      logic [3:0] opcode;                    // OPC_* when is_alu clear
      logic [3:0] arg;                       // ra/rb, caez mask or io bits
    } gen;
  } instr_u;

endpackage

// File: design/cpu_stepper.sv
/*
  six-step one-hot ring counter, marks current and last step
*/
`timescale 1ns/100ps
module cpu_stepper (
  input  logic                           in_clk,
  input  logic                           i_rst,
  output logic [cpu_arch_pkg::STEP_N-1:0] o_step,  // bit 0 is step 1
  output logic                           o_last
);
  import cpu_arch_pkg::*;

  // parked on the last step in reset, so the first cycle out of reset is step 1
  always_ff @(posedge in_clk) begin
    if (i_rst) begin
      o_step <= STEP_N'(1) << (STEP_N - 1);
    end else begin
      o_step <= {o_step[STEP_N-2:0], o_step[STEP_N-1]};  // rotate, wraps 6 -> 1
    end
  end

  assign o_last = o_step[STEP_N-1];

  a_step_onehot: assert property (@(posedge in_clk) disable iff (i_rst)
    $onehot(o_step));

endmodule

// File: design/cpu_control.sv
/*
  control unit: decodes step and instruction into set and enable strobes,
  registers the io strobes one step ahead
*/
`timescale 1ns/100ps
module cpu_control (
  input  logic                            in_clk,
  input  logic                            i_rst,
  input  logic [cpu_arch_pkg::STEP_N-1:0] i_step,
  input  cpu_isa_pkg::instr_u             i_instr,
  input  logic [cpu_arch_pkg::FLAG_W-1:0] i_flags,
  output logic                            o_s_mar,
  output logic                            o_s_ram,
  output logic                            o_s_ir,
  output logic                            o_s_iar,
  output logic                            o_s_acc,
  output logic                            o_s_tmp,
  output logic                            o_s_flags,
  output logic                            o_s_reg,
  output logic                            o_e_ram,
  output logic                            o_e_acc,
  output logic                            o_e_iar,
  output logic                            o_e_reg,
  output logic                            o_e_io,
  output logic [1:0]                      o_reg_sel,
  output logic [2:0]                      o_alu_op,
  output logic                            o_e_bus1,
  output logic                            o_io_out,
  output logic                            o_io_in,
  output logic                            o_io_addr
);
  import cpu_arch_pkg::*;
  import cpu_isa_pkg::*;

  logic io_out_q, io_in_q, io_addr_q;
  logic is_io, taken;

  assign is_io = !i_instr.alu.is_alu && (i_instr.gen.opcode == OPC_IO);
  assign taken = (i_instr.gen.arg[JC_C] & i_flags[FLAG_C]) |
                 (i_instr.gen.arg[JC_A] & i_flags[FLAG_A]) |
                 (i_instr.gen.arg[JC_E] & i_flags[FLAG_E]) |
                 (i_instr.gen.arg[JC_Z] & i_flags[FLAG_Z]);   // any masked flag set

  // ir is valid from step 3, so io strobes are registered there and pulse in step 4
  always_ff @(posedge in_clk) begin
    if (i_rst) begin
      io_out_q  <= 1'b0;
      io_in_q   <= 1'b0;
      io_addr_q <= 1'b0;
    end else begin
      io_out_q <= i_step[2] & is_io & i_instr.gen.arg[IO_OUT_BIT];
      io_in_q  <= i_step[2] & is_io & ~i_instr.gen.arg[IO_OUT_BIT];
      if (i_step[2] && is_io) begin
        io_addr_q <= i_instr.gen.arg[IO_ADDR_BIT];   // held, valid with either strobe
      end
    end
  end

  assign o_io_out  = io_out_q;
  assign o_io_in   = io_in_q;
  assign o_io_addr = io_addr_q;

  always_comb begin
    {o_s_mar, o_s_ram, o_s_ir, o_s_iar, o_s_acc, o_s_tmp, o_s_flags, o_s_reg} = '0;
    {o_e_ram, o_e_acc, o_e_iar, o_e_reg, o_e_io, o_e_bus1} = '0;
    o_reg_sel = i_instr.alu.rb;                       // rb unless noted
    o_alu_op  = ALU_ADD;
    if (i_step[0]) begin                              // mar <= iar, acc <= iar + 1
      o_e_iar  = 1'b1;
      o_s_mar  = 1'b1;
      o_e_bus1 = 1'b1;
      o_s_acc  = 1'b1;
    end else if (i_step[1]) begin                     // ir <= ram
      o_e_ram = 1'b1;
      o_s_ir  = 1'b1;
    end else if (i_step[2]) begin                     // iar <= acc
      o_e_acc = 1'b1;
      o_s_iar = 1'b1;
    end else if (i_instr.alu.is_alu) begin
      if (i_step[3]) begin                            // tmp <= rb
        o_e_reg = 1'b1;
        o_s_tmp = 1'b1;
      end else if (i_step[4]) begin                   // acc, flags <= ra op tmp
        o_e_reg   = 1'b1;
        o_reg_sel = i_instr.alu.ra;
        o_s_acc   = 1'b1;
        o_s_flags = 1'b1;
        o_alu_op  = i_instr.alu.alu_op;
      end else if (i_instr.alu.alu_op != ALU_CMP) begin   // step 6, rb <= acc
        o_e_acc = 1'b1;
        o_s_reg = 1'b1;
      end
    end else begin
      case (i_instr.gen.opcode)
        OPC_LD, OPC_ST: begin
          if (i_step[3]) begin                        // mar <= ra
            o_e_reg   = 1'b1;
            o_reg_sel = i_instr.alu.ra;
            o_s_mar   = 1'b1;
          end else if (i_step[4]) begin
            o_e_ram = (i_instr.gen.opcode == OPC_LD);
            o_s_reg = (i_instr.gen.opcode == OPC_LD);
            o_e_reg = (i_instr.gen.opcode == OPC_ST);
            o_s_ram = (i_instr.gen.opcode == OPC_ST);
          end
        end
        OPC_DATA, OPC_JCAEZ: begin
          if (i_step[3]) begin                        // operand address, iar + 1 into acc
            o_e_iar  = 1'b1;
            o_s_mar  = 1'b1;
            o_e_bus1 = 1'b1;
            o_s_acc  = 1'b1;
          end else if (i_instr.gen.opcode == OPC_DATA) begin
            o_e_ram = i_step[4];                      // rb <= operand
            o_s_reg = i_step[4];
            o_e_acc = i_step[5];                      // skip operand
            o_s_iar = i_step[5];
          end else if (i_step[4]) begin               // skip operand first
            o_e_acc = 1'b1;
            o_s_iar = 1'b1;
          end else begin                              // step 6, jump if taken
            o_e_ram = taken;
            o_s_iar = taken;
          end
        end
        OPC_JMPR: begin
          o_e_reg = i_step[3];
          o_s_iar = i_step[3];
        end
        OPC_JMP: begin
          o_e_iar = i_step[3];
          o_s_mar = i_step[3];
          o_e_ram = i_step[4];                        // iar <= operand
          o_s_iar = i_step[4];
        end
        OPC_CLF: o_s_flags = i_step[3];               // datapath loads zeros, no reg on bus
        OPC_IO: begin
          o_e_io  = io_in_q;                          // rb <= input byte
          o_s_reg = io_in_q;
        end
        default: ;
      endcase
    end
  end

  a_bus_single: assert property (@(posedge in_clk) disable iff (i_rst)
    $onehot0({o_e_ram, o_e_acc, o_e_iar, o_e_reg, o_e_io}));

  // relies on the stepper parking on step 6 and ir clearing to LD
  a_rst_quiet: assert property (@(posedge in_clk) i_rst && $past(i_rst) |->
    !(|{o_s_mar, o_s_ram, o_s_ir, o_s_iar, o_s_acc, o_s_tmp, o_s_flags, o_s_reg}));

endmodule

// File: design/cpu_alu.sv
/*
  combinational eight-operation alu with caez flags
*/
`timescale 1ns/100ps
module cpu_alu (
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_a,      // from bus
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_b,      // from bus1
  input  logic                            i_carry,
  input  logic [2:0]                      i_op,
  output logic [cpu_arch_pkg::WORD_W-1:0] o_result,
  output logic [cpu_arch_pkg::FLAG_W-1:0] o_flags
);
  import cpu_arch_pkg::*;
  import cpu_isa_pkg::*;

  logic carry;

  always_comb begin
    carry    = 1'b0;
    o_result = '0;
    case (i_op)
      ALU_ADD: {carry, o_result} = {1'b0, i_a} + {1'b0, i_b} + (WORD_W + 1)'(i_carry);
      ALU_SHR: {o_result, carry} = {i_carry, i_a};  // carry in at msb, lsb out
      ALU_SHL: {carry, o_result} = {i_a, i_carry};  // carry in at lsb, msb out
      ALU_NOT: o_result = ~i_a;
      ALU_AND: o_result = i_a & i_b;
      ALU_OR:  o_result = i_a | i_b;
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_CMP: o_result = '0;                       // compare only, a and e flags
      default: o_result = '0;
    endcase
  end

  always_comb begin
    o_flags         = '0;
    o_flags[FLAG_C] = carry;
    o_flags[FLAG_A] = (i_a > i_b);
    o_flags[FLAG_E] = (i_a == i_b);
    o_flags[FLAG_Z] = (o_result == '0);
  end

endmodule

// File: design/cpu_datapath.sv
/*
  register datapath: r0-r3, ir, iar, tmp and bus1, acc, flags
  and the shared bus multiplexer
*/
`timescale 1ns/100ps
module cpu_datapath (
  input  logic                            in_clk,
  input  logic                            i_rst,
  input  logic                            i_s_ir,
  input  logic                            i_s_iar,
  input  logic                            i_s_acc,
  input  logic                            i_s_tmp,
  input  logic                            i_s_flags,
  input  logic                            i_s_reg,
  input  logic                            i_e_ram,
  input  logic                            i_e_acc,
  input  logic                            i_e_iar,
  input  logic                            i_e_reg,
  input  logic                            i_e_io,
  input  logic                            i_e_bus1,
  input  logic [1:0]                      i_reg_sel,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_ram_data,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_io_data,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_alu_result,
  input  logic [cpu_arch_pkg::FLAG_W-1:0] i_alu_flags,
  output logic [cpu_arch_pkg::WORD_W-1:0] o_bus,
  output logic [cpu_arch_pkg::WORD_W-1:0] o_bus1,
  output cpu_isa_pkg::instr_u             o_ir,
  output logic [cpu_arch_pkg::FLAG_W-1:0] o_flags,
  output logic [cpu_arch_pkg::WORD_W-1:0] o_rb_data
);
  import cpu_arch_pkg::*;
  import cpu_isa_pkg::*;

  logic [WORD_W-1:0] gpr [4];
  logic [WORD_W-1:0] iar, acc, tmp;

  // one source at a time, control guarantees it
  always_comb begin
    o_bus = '0;
    if (i_e_ram)      o_bus = i_ram_data;
    else if (i_e_acc) o_bus = acc;
    else if (i_e_iar) o_bus = iar;
    else if (i_e_reg) o_bus = gpr[i_reg_sel];
    else if (i_e_io)  o_bus = i_io_data;
  end

  assign o_bus1    = i_e_bus1 ? WORD_W'(1) : tmp;   // constant 1 for increments
  assign o_rb_data = gpr[o_ir.alu.rb];              // out port data

  always_ff @(posedge in_clk) begin
    if (i_rst) begin
      gpr     <= '{default: '0};
      iar     <= '0;
      o_ir    <= '0;                                // LD r0,r0, idle on step 6
      o_flags <= '0;
    end else begin
      if (i_s_reg) gpr[i_reg_sel] <= o_bus;
      if (i_s_iar) iar <= o_bus;
      if (i_s_ir)  o_ir <= instr_u'(o_bus);
      if (i_s_flags) begin
        o_flags <= i_e_reg ? i_alu_flags : '0;      // clf sets flags with no reg on bus
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (i_s_acc) acc <= i_alu_result;
    if (i_s_tmp) tmp <= o_bus;
  end

  a_flags_hold: assert property (@(posedge in_clk) disable iff (i_rst)
    $changed(o_flags) |-> $past(i_s_flags));

endmodule

// File: design/cpu_ram.sv
/*
  memory address register, 256-byte ram and reset-time program load port
*/
`timescale 1ns/100ps
module cpu_ram (
  input  logic                            in_clk,
  input  logic                            i_rst,
  input  logic                            i_load_we,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_load_addr,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_load_data,
  input  logic                            i_set_mar,
  input  logic                            i_set_ram,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_bus,
  output logic [cpu_arch_pkg::WORD_W-1:0] o_data
);
  import cpu_arch_pkg::*;

  logic [WORD_W-1:0] mar;
  logic [WORD_W-1:0] mem [RAM_DEPTH];

  always_ff @(posedge in_clk) begin
    if (i_rst)          mar <= '0;
    else if (i_set_mar) mar <= i_bus;
  end

  // load port owns the array during reset, bus writes only afterwards
  always_ff @(posedge in_clk) begin
    if (i_rst) begin
      if (i_load_we) mem[i_load_addr] <= i_load_data;
    end else if (i_set_ram) begin
      mem[mar] <= i_bus;
    end
  end

  assign o_data = mem[mar];                         // async read at mar

endmodule

// File: design/cpu_top.sv
/*
  processor top level wiring the stepper, control, datapath, alu, ram and io strobes
*/
`timescale 1ns/100ps
module cpu_top (
  input  logic                            in_clk,
  input  logic                            i_rst,
  input  logic                            i_load_we,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_load_addr,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_load_data,
  input  logic [cpu_arch_pkg::WORD_W-1:0] i_io_data,
  output logic [cpu_arch_pkg::WORD_W-1:0] o_io_data,
  output logic                            o_set_output,
  output logic                            o_enable_input,
  output logic                            o_data_address   // 0 for data and 1 for address
);
  import cpu_arch_pkg::*;
  import cpu_isa_pkg::*;

  logic [STEP_N-1:0] step;
  instr_u            ir;
  logic [FLAG_W-1:0] flags, alu_flags;
  logic [WORD_W-1:0] bus, bus1, ram_data, alu_result;
  logic [1:0]        reg_sel;
  logic [2:0]        alu_op;
  logic              s_mar, s_ram, s_ir, s_iar, s_acc, s_tmp, s_flags, s_reg;
  logic              e_ram, e_acc, e_iar, e_reg, e_io, e_bus1;
  logic              alu_cin;

  assign alu_cin = flags[FLAG_C] & ~e_bus1;        // iar increments add exactly one

  cpu_stepper stepper (
    .in_clk (in_clk),
    .i_rst  (i_rst),
    .o_step (step),
    .o_last ()
  );

  cpu_control control (
    .in_clk    (in_clk),    .i_rst     (i_rst),
    .i_step    (step),      .i_instr   (ir),       .i_flags  (flags),
    .o_s_mar   (s_mar),     .o_s_ram   (s_ram),    .o_s_ir   (s_ir),
    .o_s_iar   (s_iar),     .o_s_acc   (s_acc),    .o_s_tmp  (s_tmp),
    .o_s_flags (s_flags),   .o_s_reg   (s_reg),
    .o_e_ram   (e_ram),     .o_e_acc   (e_acc),    .o_e_iar  (e_iar),
    .o_e_reg   (e_reg),     .o_e_io    (e_io),     .o_reg_sel(reg_sel),
    .o_alu_op  (alu_op),    .o_e_bus1  (e_bus1),
    .o_io_out  (o_set_output),
    .o_io_in   (o_enable_input),
    .o_io_addr (o_data_address)
  );

  cpu_datapath datapath (
    .in_clk       (in_clk),     .i_rst       (i_rst),
    .i_s_ir       (s_ir),       .i_s_iar     (s_iar),     .i_s_acc  (s_acc),
    .i_s_tmp      (s_tmp),      .i_s_flags   (s_flags),   .i_s_reg  (s_reg),
    .i_e_ram      (e_ram),      .i_e_acc     (e_acc),     .i_e_iar  (e_iar),
    .i_e_reg      (e_reg),      .i_e_io      (e_io),      .i_e_bus1 (e_bus1),
    .i_reg_sel    (reg_sel),    .i_ram_data  (ram_data),  .i_io_data(i_io_data),
    .i_alu_result (alu_result), .i_alu_flags (alu_flags),
    .o_bus        (bus),        .o_bus1      (bus1),      .o_ir     (ir),
    .o_flags      (flags),      .o_rb_data   (o_io_data)
  );

  cpu_alu alu (
    .i_a      (bus),
    .i_b      (bus1),
    .i_carry  (alu_cin),
    .i_op     (alu_op),
    .o_result (alu_result),
    .o_flags  (alu_flags)
  );

  cpu_ram ram (
    .in_clk      (in_clk),      .i_rst       (i_rst),
    .i_load_we   (i_load_we),   .i_load_addr (i_load_addr),
    .i_load_data (i_load_data), .i_set_mar   (s_mar),
    .i_set_ram   (s_ram),       .i_bus       (bus),
    .o_data      (ram_data)
  );

endmodule

// File: dv/tb_clkgen.sv
/*
  testbench clock, 20 ns period, and power-on reset held for 3 cycles
*/
`timescale 1ns/100ps
module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);
  localparam int HALF_PERIOD = 10;              // ns
  localparam int RST_CYCLES  = 3;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;                              // drops on a rising edge
  end

endmodule

// File: dv/tb_cpu.sv
/*
  program images, isa reference model, directed tests
  and byte and flag compare tasks for the cpu
*/
`timescale 1ns/100ps
module tb_cpu;
  import cpu_arch_pkg::*;
  import cpu_isa_pkg::*;

  localparam int MAX_INSTR   = 200;             // model limit per program
  localparam int TIMEOUT_CYC = 2000;            // cycles allowed per wait

  logic              clk, por_rst, tb_rst;
  logic              load_we;
  logic [WORD_W-1:0] load_addr, load_data, io_in, io_out;
  logic              set_output, enable_input, data_address;

  int                errors;
  int                seed = 32'h2b1d_3b1b;
  logic [WORD_W-1:0] prog[$];                   // program image loaded from address 0
  logic [WORD_W-1:0] in_vals[$];                // bytes offered to IN in order
  logic              exp_out[$];                // 1 for an out strobe and 0 for an in strobe
  logic              exp_addr[$];
  logic [WORD_W-1:0] exp_val[$];
  int                exp_k[$];                  // instruction index of each strobe

  tb_clkgen clkgen (
    .o_clk (clk),
    .o_rst (por_rst)
  );

  cpu_top UUT (
    .in_clk         (clk),
    .i_rst          (por_rst | tb_rst),
    .i_load_we      (load_we),
    .i_load_addr    (load_addr),
    .i_load_data    (load_data),
    .i_io_data      (io_in),
    .o_io_data      (io_out),
    .o_set_output   (set_output),
    .o_enable_input (enable_input),
    .o_data_address (data_address)
  );

  task automatic check_word(input logic [WORD_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic [WORD_W-1:0] enc_gen(input logic [3:0] opc, input logic [3:0] arg);
    return {opc, arg};
  endfunction

  task automatic add_alu(input logic [2:0] op, input logic [1:0] ra, rb);
    prog.push_back({1'b1, op, ra, rb});
  endtask

  task automatic add_data(input logic [1:0] rb, input logic [WORD_W-1:0] value);
    prog.push_back(enc_gen(OPC_DATA, {2'b00, rb}));
    prog.push_back(value);
  endtask

  task automatic add_io(input logic out, addr, input logic [1:0] rb);
    prog.push_back(enc_gen(OPC_IO, {out, addr, rb}));
  endtask

  task automatic add_halt();
    logic [WORD_W-1:0] here;
    here = WORD_W'(prog.size());
    prog.push_back(enc_gen(OPC_JMP, 4'h0));
    prog.push_back(here);                       // jump to itself so no more strobes follow
  endtask

  // reference alu from the isa rules, a and e compare a with b for every op
  task automatic alu_ref(input logic [2:0] op, input logic [WORD_W-1:0] a, b,
                         input logic cin, output logic [WORD_W-1:0] res,
                         output logic [FLAG_W-1:0] fl);
    int   sum;
    logic c;
    sum = int'(a) + int'(b) + int'(cin);
    c   = 1'b0;
    res = '0;
    case (op)
      ALU_ADD: begin
        res = WORD_W'(sum);
        c   = ((sum >> WORD_W) != 0);           // sum past the byte range
      end
      ALU_SHR: begin
        res = (a >> 1) | (WORD_W'(cin) << (WORD_W - 1));   // carry enters at the top
        c   = a[0];
      end
      ALU_SHL: begin
        res = (a << 1) | WORD_W'(cin);          // carry enters at the bottom
        c   = a[WORD_W-1];
      end
      ALU_NOT: res = ~a;
      ALU_AND: res = a & b;
      ALU_OR:  res = a | b;
      ALU_XOR: res = a ^ b;
      default: ;                                // cmp leaves zero
    endcase
    fl         = '0;
    fl[FLAG_C] = c;
    fl[FLAG_A] = (a > b);
    fl[FLAG_E] = (a == b);
    fl[FLAG_Z] = (res == '0);
  endtask

  // instruction level model that fills the expected strobe queues
  task automatic run_model();
    logic [WORD_W-1:0] mem [RAM_DEPTH];
    logic [WORD_W-1:0] regs [4];
    logic [WORD_W-1:0] iar, opnd, res;
    logic [FLAG_W-1:0] flags, fl;
    instr_u            ir;
    int                ini;
    bit                halted;
    foreach (mem[i]) mem[i] = '0;
    foreach (prog[i]) mem[i] = prog[i];
    foreach (regs[i]) regs[i] = '0;
    iar    = '0;
    flags  = '0;
    ini    = 0;
    halted = 1'b0;
    exp_out.delete();
    exp_addr.delete();
    exp_val.delete();
    exp_k.delete();
    for (int k = 0; k < MAX_INSTR && !halted; k++) begin
      ir   = instr_u'(mem[iar]);
      iar  = iar + WORD_W'(1);
      opnd = mem[iar];                          // byte after the instruction
      if (ir.alu.is_alu) begin
        alu_ref(ir.alu.alu_op, regs[ir.alu.ra], regs[ir.alu.rb], flags[FLAG_C], res, fl);
        flags = fl;
        if (ir.alu.alu_op != ALU_CMP) regs[ir.alu.rb] = res;
      end else begin
        case (ir.gen.opcode)
          OPC_LD:   regs[ir.alu.rb] = mem[regs[ir.alu.ra]];
          OPC_ST:   mem[regs[ir.alu.ra]] = regs[ir.alu.rb];
          OPC_DATA: begin
            regs[ir.alu.rb] = opnd;
            iar = iar + WORD_W'(1);
          end
          OPC_JMPR: iar = regs[ir.alu.rb];
          OPC_JMP: begin
            halted = (opnd == iar - WORD_W'(1));
            iar    = opnd;
          end
          OPC_JCAEZ: iar = |(ir.gen.arg & flags) ? opnd : iar + WORD_W'(1);  // mask in flag order
          OPC_CLF:   flags = '0;
          OPC_IO: begin
            exp_out.push_back(ir.gen.arg[IO_OUT_BIT]);
            exp_addr.push_back(ir.gen.arg[IO_ADDR_BIT]);
            exp_val.push_back(regs[ir.alu.rb]);
            exp_k.push_back(k);
            if (!ir.gen.arg[IO_OUT_BIT]) begin
              regs[ir.alu.rb] = in_vals[ini];
              ini++;
            end
          end
          default: ;
        endcase
      end
    end
  endtask

  // load the image under reset, release and match every io strobe to the model
  task automatic run_program(input string name);
    int cyc, n, in_i;
    run_model();
    @(posedge clk);
    tb_rst <= 1'b1;
    foreach (prog[i]) begin
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= WORD_W'(i);
      load_data <= prog[i];
    end
    @(posedge clk);
    load_we <= 1'b0;
    io_in   <= (in_vals.size() > 0) ? in_vals[0] : '0;
    @(negedge clk);
    check_flag(set_output, 1'b0, {name, " set_output in reset"});
    check_flag(enable_input, 1'b0, {name, " enable_input in reset"});
    @(posedge clk);
    tb_rst <= 1'b0;
    @(posedge clk);                             // stepper moves to step 1 here
    cyc  = 0;
    n    = 0;
    in_i = 1;
    while (n < exp_out.size() && cyc < TIMEOUT_CYC) begin
      @(negedge clk);
      cyc++;
      if (set_output || enable_input) begin
        check_flag(set_output, exp_out[n], {name, " strobe kind"});
        if (exp_out[n]) check_word(io_out, exp_val[n], {name, " out data"});
        check_flag(data_address, exp_addr[n], {name, " data/address"});
        check_word(WORD_W'(cyc - STEP_N * exp_k[n]), WORD_W'(4), {name, " strobe step"});
        n++;
        if (enable_input) begin
          @(posedge clk);                       // byte is captured on this edge
          io_in <= (in_i < in_vals.size()) ? in_vals[in_i] : '0;
          in_i++;
        end
      end
    end
    if (n < exp_out.size()) begin
      errors++;
      $display("%s: timed out after %0d cycles with %0d of %0d io strobes seen",
               name, cyc, n, exp_out.size());
    end
    prog.delete();
    in_vals.delete();
  endtask

  task automatic test_data_out();
    add_data(2'd0, 8'h5a);
    add_data(2'd1, 8'hc3);
    add_io(1'b1, 1'b0, 2'd0);                   // back to back outs six cycles apart
    add_io(1'b1, 1'b0, 2'd1);
    add_data(2'd2, 8'h00);
    add_io(1'b1, 1'b0, 2'd2);
    add_io(1'b1, 1'b1, 2'd1);                   // address form
    add_halt();
    run_program("data_out");
  endtask

  task automatic test_alu_ops();
    logic [WORD_W-1:0] a, b;
    for (int op = 0; op < 8; op++) begin
      a = WORD_W'($random(seed));
      b = WORD_W'($random(seed));
      add_data(2'd0, a);
      add_data(2'd1, b);
      add_alu(3'(op), 2'd0, 2'd1);
      add_io(1'b1, 1'b0, 2'd1);                 // result or b again after cmp
    end
    add_halt();
    run_program("alu_ops");
  endtask

  // flags from op then jcaez with markers s and ~s telling the paths apart
  task automatic add_branch(input logic [2:0] op, input logic [WORD_W-1:0] a, b,
                            input logic [3:0] mask);
    logic [WORD_W-1:0] s;
    s = WORD_W'(prog.size());
    add_data(2'd0, a);
    add_data(2'd1, b);
    add_alu(op, 2'd0, 2'd1);
    prog.push_back(enc_gen(OPC_JCAEZ, mask));
    prog.push_back(s + WORD_W'(12));            // taken target
    add_data(2'd2, s);
    add_io(1'b1, 1'b0, 2'd2);
    prog.push_back(enc_gen(OPC_JMP, 4'h0));
    prog.push_back(s + WORD_W'(15));            // join after taken path
    add_data(2'd2, ~s);
    add_io(1'b1, 1'b0, 2'd2);
  endtask

  task automatic test_flag_jumps();
    add_branch(ALU_ADD, 8'hf0, 8'h20, 4'b1000); // carry out
    add_branch(ALU_ADD, 8'h01, 8'h02, 4'b1000);
    add_branch(ALU_CMP, 8'h09, 8'h03, 4'b0100); // a larger
    add_branch(ALU_CMP, 8'h03, 8'h09, 4'b0100);
    add_branch(ALU_CMP, 8'h07, 8'h07, 4'b0010); // equal
    add_branch(ALU_CMP, 8'h07, 8'h08, 4'b0010);
    add_branch(ALU_XOR, 8'h5a, 8'h5a, 4'b0001); // zero
    add_branch(ALU_XOR, 8'h5a, 8'h5b, 4'b0001);
    add_data(2'd0, 8'hff);
    add_data(2'd1, 8'h01);
    add_alu(ALU_ADD, 2'd0, 2'd1);               // leaves carry set
    prog.push_back(enc_gen(OPC_CLF, 4'h0));
    add_data(2'd1, 8'h10);
    add_data(2'd0, 8'h05);
    add_alu(ALU_ADD, 2'd0, 2'd1);               // 0x15 without a stale carry
    add_io(1'b1, 1'b0, 2'd1);
    add_halt();
    run_program("flag_jumps");
  endtask

  task automatic test_mem_jumps();
    logic [WORD_W-1:0] d;
    d = WORD_W'($random(seed));
    add_data(2'd0, 8'h80);                      // 0
    add_data(2'd1, d);                          // 2
    prog.push_back(enc_gen(OPC_ST, {2'd0, 2'd1}));  // 4 stores d at 80
    add_data(2'd1, 8'h00);                      // 5
    prog.push_back(enc_gen(OPC_LD, {2'd0, 2'd2}));  // 7 loads r2 from 80
    add_io(1'b1, 1'b0, 2'd2);                   // 8
    prog.push_back(enc_gen(OPC_JMP, 4'h0));     // 9
    prog.push_back(8'd14);
    add_data(2'd3, 8'hee);                      // 11 skipped
    add_io(1'b1, 1'b0, 2'd3);                   // 13 skipped
    add_data(2'd3, 8'd19);                      // 14
    prog.push_back(enc_gen(OPC_JMPR, {2'd0, 2'd3}));  // 16
    add_io(1'b1, 1'b0, 2'd2);                   // 17 skipped
    add_io(1'b1, 1'b0, 2'd1);                   // 18 skipped
    add_io(1'b1, 1'b0, 2'd3);                   // 19
    add_halt();
    run_program("mem_jumps");
  endtask

  task automatic test_io_in();
    in_vals.push_back(8'h77);
    in_vals.push_back(WORD_W'($random(seed)));
    add_io(1'b0, 1'b0, 2'd1);                   // data form in
    add_io(1'b1, 1'b0, 2'd1);
    add_io(1'b0, 1'b1, 2'd2);                   // address form in
    add_io(1'b1, 1'b1, 2'd2);
    add_io(1'b1, 1'b0, 2'd1);
    add_halt();
    run_program("io_in");
  endtask

  initial begin
    int t;
    errors    = 0;
    tb_rst    = 1'b1;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    io_in     = '0;
    t         = 0;
    while (por_rst !== 1'b0 && t < TIMEOUT_CYC) begin
      @(posedge clk);
      t++;
    end
    if (por_rst !== 1'b0) begin
      errors++;
      $display("power-on reset was never released");
    end
    test_data_out();
    test_alu_ops();
    test_flag_jumps();
    test_mem_jumps();
    test_io_in();
    $display("tb_cpu finished with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: build.f
design/cpu_arch_pkg.sv
design/cpu_isa_pkg.sv
design/cpu_stepper.sv
design/cpu_control.sv
design/cpu_alu.sv
design/cpu_datapath.sv
design/cpu_ram.sv
design/cpu_top.sv
dv/tb_clkgen.sv
dv/tb_cpu.sv

// File: Makefile
# Verilator flow for the 8-bit cpu; every variable can be set on the command line

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_cpu
RTL_TOP   ?= cpu_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --timing --assert

SRCS := $(shell grep '\.sv$$' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
